// File: hdl/ip_apb_pkg.sv
// Shared definitions for the APB peripheral island
// Address map, register indices and LFSR constants
// Memory request and APB request/response structs
// Address decode union

`default_nettype none

package ip_apb_pkg;

  // Device select codes in address bits 15:12
  localparam logic [3:0] DEV_PWM = 4'd0;
  localparam logic [3:0] DEV_RNG = 4'd1;

  // PWM register indices
  localparam logic [3:0] PWM_CTRL = 4'd0;
  localparam logic [3:0] PWM_PSC  = 4'd1;
  localparam logic [3:0] PWM_ARR  = 4'd2;
  localparam logic [3:0] PWM_CMP  = 4'd3;
  localparam logic [3:0] PWM_STAT = 4'd4;

  // PWM CTRL bit positions
  localparam int PWM_CTRL_EN_BIT = 0;
  localparam int PWM_CTRL_IE_BIT = 1;

  // RNG register indices
  localparam logic [3:0] RNG_SEED = 4'd0;
  localparam logic [3:0] RNG_DATA = 4'd1;

  // Galois feedback mask and reset state of the LFSR
  localparam logic [31:0] LFSR_POLY        = 32'h8020_0003;
  localparam logic [31:0] RNG_DEFAULT_SEED = 32'h0000_0001;

  // Field view of a peripheral address
  typedef struct packed {
    logic [15:0] upper;
    logic [3:0]  dev;
    logic [5:0]  reserved;
    logic [3:0]  reg_idx;
    logic [1:0]  byte_off;
  } mmio_fields_t;

  // Same address seen as a raw word or as fields
  typedef union packed {
    logic [31:0]  word;
    mmio_fields_t f;
  } mmio_addr_u;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
  } mem_req_t;

  // Shared by both peripherals, psel travels on its own
  typedef struct packed {
    logic [31:0] paddr;
    logic        pwrite;
    logic        penable;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/mem2apb.sv
// Memory port to APB4 bridge
// Request capture, address decode, setup/access sequencer
// and the response mux back to the memory side

`timescale 1ns/10ps
`default_nettype none

module mem2apb (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mem_valid_i,
  input  ip_apb_pkg::mem_req_t mem_req_i,
  output logic                 mem_ready_o,
  output logic [31:0]          mem_rdata_o,
  output logic                 mem_err_o,
  output ip_apb_pkg::apb_req_t apb_req_o,
  output logic                 psel_pwm_o,
  output logic                 psel_rng_o,
  input  ip_apb_pkg::apb_rsp_t pwm_rsp_i,
  input  ip_apb_pkg::apb_rsp_t rng_rsp_i
);

  import ip_apb_pkg::*;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } state_e;

  state_e     state_q;
  state_e     state_d;
  mem_req_t   req_q;
  mmio_addr_u addr;
  logic       hit_pwm;
  logic       hit_rng;
  logic       unmapped;
  logic       psel_active;
  logic       xfer_done;
  apb_rsp_t   sel_rsp;

  // Request is taken when the FSM leaves IDLE
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && mem_valid_i) begin
      req_q <= mem_req_i;
    end
  end

  assign addr.word = req_q.addr;

  // Anything above bit 15 or an unknown device code is unmapped
  always_comb begin
    hit_pwm  = (addr.f.upper == '0) && (addr.f.dev == DEV_PWM);
    hit_rng  = (addr.f.upper == '0) && (addr.f.dev == DEV_RNG);
    unmapped = !(hit_pwm || hit_rng);
  end

  // Unmapped accesses are answered here with an error
  always_comb begin
    sel_rsp         = '0;
    sel_rsp.pready  = 1'b1;
    sel_rsp.pslverr = 1'b1;
    if (hit_pwm) begin
      sel_rsp = pwm_rsp_i;
    end else if (hit_rng) begin
      sel_rsp = rng_rsp_i;
    end
  end

  assign xfer_done = (state_q == ACCESS) && sel_rsp.pready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (mem_valid_i) begin
          state_d = SETUP;
        end
      end
      SETUP:   state_d = ACCESS;
      ACCESS: begin
        if (sel_rsp.pready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // APB side
  assign psel_active       = (state_q == SETUP) || (state_q == ACCESS);
  assign psel_pwm_o        = psel_active && hit_pwm;
  assign psel_rng_o        = psel_active && hit_rng;
  assign apb_req_o.paddr   = addr.word;
  assign apb_req_o.pwrite  = req_q.we;
  assign apb_req_o.penable = (state_q == ACCESS) && !unmapped;
  assign apb_req_o.pwdata  = req_q.wdata;

  // Memory response, only meaningful in the completing cycle
  assign mem_ready_o = xfer_done;
  assign mem_rdata_o = xfer_done ? sel_rsp.prdata : 32'd0;
  assign mem_err_o   = xfer_done && sel_rsp.pslverr;

endmodule

`default_nettype wire

// File: hdl/apb4_pwm.sv
// APB4 PWM timer
// Prescaler, period counter, compare output and sticky overflow interrupt

`timescale 1ns/10ps
`default_nettype none

module apb4_pwm (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 psel_i,
  input  ip_apb_pkg::apb_req_t apb_req_i,
  output ip_apb_pkg::apb_rsp_t apb_rsp_o,
  output logic                 pwm_o,
  output logic                 irq_o
);

  import ip_apb_pkg::*;

  mmio_addr_u  addr;
  logic        apb_wr;
  logic        en;
  logic        tick;
  logic        wrap;
  logic        stat_clr;
  logic [1:0]  ctrl_q;
  logic [15:0] psc_q;
  logic [15:0] arr_q;
  logic [15:0] cmp_q;
  logic        ovf_q;
  logic [15:0] psc_cnt_q;
  logic [15:0] cnt_q;

  assign addr.word = apb_req_i.paddr;
  assign apb_wr    = psel_i && apb_req_i.penable && apb_req_i.pwrite;
  assign en        = ctrl_q[PWM_CTRL_EN_BIT];

  // Config registers, written at the end of the access phase
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
      psc_q  <= '0;
      arr_q  <= '0;
      cmp_q  <= '0;
    end else if (apb_wr) begin
      case (addr.f.reg_idx)
        PWM_CTRL: ctrl_q <= apb_req_i.pwdata[1:0];
        PWM_PSC:  psc_q  <= apb_req_i.pwdata[15:0];
        PWM_ARR:  arr_q  <= apb_req_i.pwdata[15:0];
        PWM_CMP:  cmp_q  <= apb_req_i.pwdata[15:0];
        default:  ;
      endcase
    end
  end

  // >= keeps the counters sane if a limit shrinks below the count
  assign tick = en && (psc_cnt_q >= psc_q);
  assign wrap = tick && (cnt_q >= arr_q);

  // Counters restart from zero whenever the timer is disabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      psc_cnt_q <= '0;
      cnt_q     <= '0;
    end else if (!en) begin
      psc_cnt_q <= '0;
      cnt_q     <= '0;
    end else if (tick) begin
      psc_cnt_q <= '0;
      cnt_q     <= wrap ? 16'd0 : cnt_q + 16'd1;
    end else begin
      psc_cnt_q <= psc_cnt_q + 16'd1;
    end
  end

  // Sticky overflow, a new wrap wins over a clear in the same cycle
  assign stat_clr = apb_wr && (addr.f.reg_idx == PWM_STAT) && apb_req_i.pwdata[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ovf_q <= 1'b0;
    end else if (wrap) begin
      ovf_q <= 1'b1;
    end else if (stat_clr) begin
      ovf_q <= 1'b0;
    end
  end

  assign pwm_o = en && (cnt_q < cmp_q);
  assign irq_o = ovf_q && ctrl_q[PWM_CTRL_IE_BIT];

  // Read mux, no wait states
  always_comb begin
    apb_rsp_o         = '0;
    apb_rsp_o.pready  = 1'b1;
    case (addr.f.reg_idx)
      PWM_CTRL: apb_rsp_o.prdata = {30'd0, ctrl_q};
      PWM_PSC:  apb_rsp_o.prdata = {16'd0, psc_q};
      PWM_ARR:  apb_rsp_o.prdata = {16'd0, arr_q};
      PWM_CMP:  apb_rsp_o.prdata = {16'd0, cmp_q};
      PWM_STAT: apb_rsp_o.prdata = {31'd0, ovf_q};
      default:  apb_rsp_o.prdata = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/apb4_rng.sv
// APB4 random-number generator
// Seed register and a 32-bit Galois LFSR stepped on each data read

`timescale 1ns/10ps
`default_nettype none

module apb4_rng (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 psel_i,
  input  ip_apb_pkg::apb_req_t apb_req_i,
  output ip_apb_pkg::apb_rsp_t apb_rsp_o
);

  import ip_apb_pkg::*;

  mmio_addr_u  addr;
  logic        apb_wr;
  logic        apb_rd;
  logic [31:0] seed_load;
  logic [31:0] seed_q;
  logic [31:0] lfsr_q;

  // One Galois step, shift right and fold in the mask on a 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] cur);
    logic [31:0] nxt;
    nxt = cur >> 1;
    if (cur[0]) begin
      nxt = nxt ^ LFSR_POLY;
    end
    return nxt;
  endfunction

  assign addr.word = apb_req_i.paddr;
  assign apb_wr    = psel_i && apb_req_i.penable && apb_req_i.pwrite;
  assign apb_rd    = psel_i && apb_req_i.penable && !apb_req_i.pwrite;

  // All-zero state would lock up the LFSR
  assign seed_load = (apb_req_i.pwdata == 32'd0) ? RNG_DEFAULT_SEED : apb_req_i.pwdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seed_q <= RNG_DEFAULT_SEED;
      lfsr_q <= RNG_DEFAULT_SEED;
    end else if (apb_wr && addr.f.reg_idx == RNG_SEED) begin
      seed_q <= seed_load;
      lfsr_q <= seed_load;
    end else if (apb_rd && addr.f.reg_idx == RNG_DATA) begin
      lfsr_q <= lfsr_step(lfsr_q);
    end
  end

  // DATA returns the state before this read's step
  always_comb begin
    apb_rsp_o        = '0;
    apb_rsp_o.pready = 1'b1;
    case (addr.f.reg_idx)
      RNG_SEED: apb_rsp_o.prdata = seed_q;
      RNG_DATA: apb_rsp_o.prdata = lfsr_q;
      default:  apb_rsp_o.prdata = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/ip_apb_wrapper.sv
// Top of the APB peripheral island
// Memory-to-APB bridge, PWM timer and RNG

`timescale 1ns/10ps
`default_nettype none

module ip_apb_wrapper (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mem_valid_i,
  input  ip_apb_pkg::mem_req_t mem_req_i,
  output logic                 mem_ready_o,
  output logic [31:0]          mem_rdata_o,
  output logic                 mem_err_o,
  output logic                 pwm_o,
  output logic                 irq_o
);

  import ip_apb_pkg::*;

  apb_req_t apb_req;
  apb_rsp_t pwm_rsp;
  apb_rsp_t rng_rsp;
  logic     psel_pwm;
  logic     psel_rng;

  mem2apb u_mem2apb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_valid_i(mem_valid_i),
    .mem_req_i  (mem_req_i),
    .mem_ready_o(mem_ready_o),
    .mem_rdata_o(mem_rdata_o),
    .mem_err_o  (mem_err_o),
    .apb_req_o  (apb_req),
    .psel_pwm_o (psel_pwm),
    .psel_rng_o (psel_rng),
    .pwm_rsp_i  (pwm_rsp),
    .rng_rsp_i  (rng_rsp)
  );

  // PWM also drives the island interrupt
  apb4_pwm u_apb4_pwm (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .psel_i   (psel_pwm),
    .apb_req_i(apb_req),
    .apb_rsp_o(pwm_rsp),
    .pwm_o    (pwm_o),
    .irq_o    (irq_o)
  );

  apb4_rng u_apb4_rng (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .psel_i   (psel_rng),
    .apb_req_i(apb_req),
    .apb_rsp_o(rng_rsp)
  );

endmodule

`default_nettype wire

// File: testbench/ip_apb_wrapper_sva.sv
// Concurrent checks bound to the bridge
// Ready pulse width, APB phase order, psel exclusivity and stability

`timescale 1ns/10ps
`default_nettype none

module ip_apb_wrapper_sva (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 mem_ready_i,
  input logic [1:0]           state_i,
  input logic                 psel_pwm_i,
  input logic                 psel_rng_i,
  input ip_apb_pkg::apb_req_t apb_req_i
);

  // Encoding of the bridge FSM
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_ready_i |=> !mem_ready_i)
    else $error("mem_ready_o stayed high for more than one cycle");

  setup_then_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_i == ST_SETUP |=> state_i == ST_ACCESS)
    else $error("SETUP was not followed by ACCESS");

  psel_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(psel_pwm_i && psel_rng_i))
    else $error("Both peripherals selected at once");

  // penable marks the access phase, psel must match the setup cycle
  psel_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_req_i.penable |-> $stable({psel_pwm_i, psel_rng_i}))
    else $error("psel changed during the access phase");

endmodule

bind mem2apb ip_apb_wrapper_sva i_ip_apb_wrapper_sva (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .mem_ready_i(mem_ready_o),
  .state_i    (state_q),
  .psel_pwm_i (psel_pwm_o),
  .psel_rng_i (psel_rng_o),
  .apb_req_i  (apb_req_o)
);

`default_nettype wire

// File: testbench/tb_ip_apb_wrapper.sv
// Testbench for the APB peripheral island
// Random bus stimulus checked against a model of the registers,
// the LFSR and the PWM output, and a closing error report

`timescale 1ns/10ps
`default_nettype none

module tb_ip_apb_wrapper;

  import ip_apb_pkg::*;

  localparam int N_RAND      = 40;
  localparam int N_LFSR      = 8;
  localparam int N_BAD       = 12;
  localparam int N_PWM       = 6;
  // PSC up to 3 and ARR up to 7 in the waveform test
  localparam int MAX_PERIOD  = 32;
  localparam int IRQ_PSC     = 1;
  localparam int IRQ_ARR     = 5;
  localparam int IRQ_PERIOD  = (IRQ_ARR + 1) * (IRQ_PSC + 1);
  localparam int N_ACCESS    = N_RAND + 2 * (N_LFSR + 3) + N_BAD + 4 + 5 * N_PWM + 12;
  localparam int CYCLE_LIMIT = 4 * N_ACCESS + N_PWM * MAX_PERIOD + 4 * IRQ_PERIOD + 100;

  logic        clk;
  logic        rst_n;
  logic        mem_valid;
  mem_req_t    mem_req;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        mem_err;
  logic        pwm;
  logic        irq;
  integer      seed;
  int          cycles = 0;
  int          value_errs = 0;
  int          hs_errs = 0;
  logic [15:0] m_psc;
  logic [15:0] m_arr;
  logic [15:0] m_cmp;
  logic [31:0] m_seed;
  logic [31:0] m_lfsr;
  logic [31:0] rd;
  logic        err;

  ip_apb_wrapper i_ip_apb_wrapper (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .mem_valid_i(mem_valid),
    .mem_req_i  (mem_req),
    .mem_ready_o(mem_ready),
    .mem_rdata_o(mem_rdata),
    .mem_err_o  (mem_err),
    .pwm_o      (pwm),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] reg_addr(input logic [3:0] dev, input logic [3:0] idx);
    return {16'h0000, dev, 6'd0, idx, 2'b00};
  endfunction

  // Shift right and fold in the feedback mask when a 1 drops out
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] mask;
    mask = s[0] ? LFSR_POLY : 32'd0;
    return {1'b0, s[31:1]} ^ mask;
  endfunction

  // Ready is expected exactly two cycles after valid rises
  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [31:0] wdata);
    int waited;
    waited = 0;
    @(negedge clk);
    mem_valid     = 1'b1;
    mem_req.addr  = addr;
    mem_req.we    = we;
    mem_req.wdata = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!mem_ready && waited < 8);
    if (!mem_ready) begin
      hs_errs++;
      $display("No ready for the access to %h within %0d cycles", addr, waited);
    end else if (waited != 2) begin
      hs_errs++;
      $display("Ready for the access to %h came %0d cycles after valid", addr, waited);
    end
    rd        = mem_rdata;
    err       = mem_err;
    mem_valid = 1'b0;
  endtask

  task automatic mapped_access(input string name, input logic [31:0] addr, input logic we,
                               input logic [31:0] wdata, input logic [31:0] exp);
    bus_access(addr, we, wdata);
    if (err !== 1'b0) begin
      value_errs++;
      $display("** Error %s: expected err 0, actual err %b", name, err);
    end
    if (!we && rd !== exp) begin
      value_errs++;
      $display("** Error %s: expected %h, actual %h", name, exp, rd);
    end
  endtask

  task automatic pwm_write(input string name, input logic [3:0] idx, input logic [31:0] data);
    mapped_access(name, reg_addr(DEV_PWM, idx), 1'b1, data, 32'd0);
  endtask

  task automatic load_seed(input logic [31:0] s);
    mapped_access("seed write", reg_addr(DEV_RNG, RNG_SEED), 1'b1, s, 32'd0);
    m_seed = (s == 32'd0) ? RNG_DEFAULT_SEED : s;
    m_lfsr = m_seed;
  endtask

  task automatic read_data(input string name);
    mapped_access(name, reg_addr(DEV_RNG, RNG_DATA), 1'b0, 32'd0, m_lfsr);
    m_lfsr = lfsr_next(m_lfsr);
  endtask

  task automatic readback_all(input string name);
    mapped_access(name, reg_addr(DEV_PWM, PWM_PSC), 1'b0, 32'd0, {16'd0, m_psc});
    mapped_access(name, reg_addr(DEV_PWM, PWM_ARR), 1'b0, 32'd0, {16'd0, m_arr});
    mapped_access(name, reg_addr(DEV_PWM, PWM_CMP), 1'b0, 32'd0, {16'd0, m_cmp});
    mapped_access(name, reg_addr(DEV_RNG, RNG_SEED), 1'b0, 32'd0, m_seed);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    int          highs;
    int          period;
    int          exp_highs;
    int          n;
    seed      = 32'h879f_cb57;
    rst_n     = 1'b0;
    mem_valid = 1'b0;
    mem_req   = '0;
    m_psc     = '0;
    m_arr     = '0;
    m_cmp     = '0;
    m_seed    = RNG_DEFAULT_SEED;
    m_lfsr    = RNG_DEFAULT_SEED;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // Random register writes and read-backs where r[2] selects a write
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      a = $random(seed);
      case (r[1:0])
        2'd0: m_psc = r[2] ? a[15:0] : m_psc;
        2'd1: m_arr = r[2] ? a[15:0] : m_arr;
        2'd2: m_cmp = r[2] ? a[15:0] : m_cmp;
        default: ;
      endcase
      case (r[1:0])
        2'd0: mapped_access("readback psc", reg_addr(DEV_PWM, PWM_PSC), r[2], a, {16'd0, m_psc});
        2'd1: mapped_access("readback arr", reg_addr(DEV_PWM, PWM_ARR), r[2], a, {16'd0, m_arr});
        2'd2: mapped_access("readback cmp", reg_addr(DEV_PWM, PWM_CMP), r[2], a, {16'd0, m_cmp});
        default: begin
          if (r[2]) begin
            load_seed(a);
          end else begin
            mapped_access("readback seed", reg_addr(DEV_RNG, RNG_SEED), 1'b0, 32'd0, m_seed);
          end
        end
      endcase
    end

    // LFSR from a random seed and then from a zero seed
    for (int s = 0; s < 2; s++) begin
      a = $random(seed);
      load_seed((s == 0) ? a : 32'd0);
      for (int i = 0; i < N_LFSR; i++) begin
        read_data("lfsr data");
      end
      mapped_access("lfsr seed", reg_addr(DEV_RNG, RNG_SEED), 1'b0, 32'd0, m_seed);
      read_data("lfsr after seed read");
    end

    // Bad device code or nonzero upper bits
    for (int i = 0; i < N_BAD; i++) begin
      r = $random(seed);
      a = $random(seed);
      if (r[0]) begin
        a[31:16] = 16'd0;
        a[15:12] = (a[15:12] < 4'd2) ? a[15:12] + 4'd2 : a[15:12];
      end else if (a[31:16] == 16'd0) begin
        a[16] = 1'b1;
      end
      bus_access(a, r[1], r);
      if (err !== 1'b1 || rd !== 32'd0) begin
        value_errs++;
        $display("** Error decode %h: expected err 1 rdata %h, actual err %b rdata %h",
                 a, 32'd0, err, rd);
      end
    end
    readback_all("decode readback");

    // High cycles over one full period
    // The first run has CMP above ARR
    for (int i = 0; i < N_PWM; i++) begin
      r     = $random(seed);
      m_psc = {14'd0, r[1:0]};
      m_arr = {13'd0, r[4:2]};
      m_cmp = (i == 0) ? m_arr + 16'd2 : {12'd0, r[8:5]} % (m_arr + 16'd2);
      pwm_write("pwm psc", PWM_PSC, {16'd0, m_psc});
      pwm_write("pwm arr", PWM_ARR, {16'd0, m_arr});
      pwm_write("pwm cmp", PWM_CMP, {16'd0, m_cmp});
      pwm_write("pwm enable", PWM_CTRL, 32'd1);
      period    = (int'(m_arr) + 1) * (int'(m_psc) + 1);
      exp_highs = ((m_cmp > m_arr) ? int'(m_arr) + 1 : int'(m_cmp)) * (int'(m_psc) + 1);
      highs     = 0;
      repeat (period) begin
        @(negedge clk);
        highs = highs + (pwm ? 1 : 0);
      end
      if (highs != exp_highs) begin
        value_errs++;
        $display("** Error pwm duty: expected %0d, actual %0d", exp_highs, highs);
      end
      pwm_write("pwm disable", PWM_CTRL, 32'd0);
    end

    // Flag sets with the interrupt masked
    // irq then follows the enable and the clear
    m_psc = 16'(IRQ_PSC);
    m_arr = 16'(IRQ_ARR);
    pwm_write("irq psc", PWM_PSC, {16'd0, m_psc});
    pwm_write("irq arr", PWM_ARR, {16'd0, m_arr});
    // Overflows of the waveform runs left the flag set
    pwm_write("irq stat init clear", PWM_STAT, 32'd1);
    pwm_write("irq counter on", PWM_CTRL, 32'd1);
    n = 0;
    repeat (IRQ_PERIOD + 2) begin
      @(negedge clk);
      n = n + (irq ? 1 : 0);
    end
    if (n != 0) begin
      value_errs++;
      $display("** Error irq masked: expected 0 high cycles, actual %0d", n);
    end
    mapped_access("irq stat set", reg_addr(DEV_PWM, PWM_STAT), 1'b0, 32'd0, 32'd1);
    pwm_write("irq enable", PWM_CTRL, 32'd3);
    @(negedge clk);
    if (irq !== 1'b1) begin
      value_errs++;
      $display("** Error irq enabled: expected 1, actual %b", irq);
    end
    // Counter stopped so the clear is not raced by a new overflow
    pwm_write("irq counter off", PWM_CTRL, 32'd2);
    pwm_write("irq stat clear", PWM_STAT, 32'd1);
    @(negedge clk);
    if (irq !== 1'b0) begin
      value_errs++;
      $display("** Error irq cleared: expected 0, actual %b", irq);
    end
    mapped_access("irq stat clear", reg_addr(DEV_PWM, PWM_STAT), 1'b0, 32'd0, 32'd0);
    pwm_write("irq restart", PWM_CTRL, 32'd3);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!irq && n < IRQ_PERIOD + 8);
    if (n != IRQ_PERIOD + 1) begin
      value_errs++;
      $display("** Error irq next overflow: expected %0d cycles, actual %0d",
               IRQ_PERIOD + 1, n);
    end
    pwm_write("irq off", PWM_CTRL, 32'd0);
    pwm_write("irq final clear", PWM_STAT, 32'd1);

    $display("Errors: %0d value, %0d handshake", value_errs, hs_errs);
    if (value_errs == 0 && hs_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ip_apb_wrapper.f
hdl/ip_apb_pkg.sv
hdl/mem2apb.sv
hdl/apb4_pwm.sv
hdl/apb4_rng.sv
hdl/ip_apb_wrapper.sv
testbench/ip_apb_wrapper_sva.sv
testbench/tb_ip_apb_wrapper.sv

// File: Makefile
# Verilator flow for the APB peripheral island

TOP   = tb_ip_apb_wrapper
FLIST = ip_apb_wrapper.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

# Pass only when the run prints the pass message
sim:
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
